// ==== Bender.yml ====
package:
  name: i2c_master

sources:
  - hdl/i2c_types_pkg.sv
  - hdl/i2c_bus_pkg.sv
  - hdl/i2c_transfer_sequencer.sv
  - hdl/i2c_bit_engine.sv
  - hdl/i2c_read_capture.sv
  - hdl/i2c_master.sv
  - target: test
    files:
      - verif/i2c_slave_model.sv
      - verif/i2c_master_tb.sv

// ==== hdl/i2c_bit_engine.sv ====
`default_nettype none

module i2c_bit_engine (
    input  logic                      clock,
    input  logic                      reset_n,
    input  i2c_types_pkg::divider_t   divider,
    input  i2c_bus_pkg::bit_request_t request,
    input  logic                      scl_in,
    output i2c_bus_pkg::bit_status_t  status,
    output logic                      scl_drive_low,
    output logic                      sda_drive_low
);
    import i2c_types_pkg::*;
    import i2c_bus_pkg::*;

    divider_t       divider_count;
    logic           tick;
    logic           active;
    quarter_t       quarter;
    bit_op_t        op;
    logic           send_value;
    stretch_count_t stretch_count;
    stretch_count_t stretch_next;
    logic           stretch_expired;
    logic           data_op;
    logic           high_complete;

    assign tick            = active && (divider_count == divider);
    assign data_op         = (op == op_send_bit) || (op == op_receive_bit);
    assign stretch_next    = stretch_count + 1'b1;
    assign stretch_expired = (stretch_next == stretch_timeout_ticks);
    // SCL has been high for a whole quarter
    assign high_complete   = scl_in && (stretch_count == '0);

    always_comb begin
        status.done          = tick && (quarter == quarter_fall);
        status.aborted       = tick && (quarter == quarter_high) && !scl_in && stretch_expired;
        // SDA still valid, SCL has not been pulled low yet
        status.sample_strobe = tick && (quarter == quarter_high) && high_complete && data_op;
        status.op            = op;
    end

    ////////////////////////////////////////////////////////////
    // line levels
    ////////////////////////////////////////////////////////////

    // levels are held between operations, abort and reset leave op_stop
    always_comb begin
        scl_drive_low = 1'b0;
        sda_drive_low = 1'b0;
        case (op)
            op_start,
            op_restart: begin
                // SDA falls in the last quarter, SCL follows once finished
                scl_drive_low = ((quarter == quarter_setup) && (op == op_restart)) ||
                                !active;
                sda_drive_low = (quarter == quarter_fall);
            end
            op_stop: begin
                scl_drive_low = (quarter == quarter_setup);
                sda_drive_low = (quarter != quarter_fall);
            end
            op_send_bit: begin
                scl_drive_low = (quarter == quarter_setup) || (quarter == quarter_fall);
                sda_drive_low = !send_value;
            end
            default: begin
                scl_drive_low = (quarter == quarter_setup) || (quarter == quarter_fall);
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // quarter timing and stretch timeout
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            active        <= 1'b0;
            quarter       <= quarter_fall;
            op            <= op_stop;
            divider_count <= '0;
            stretch_count <= '0;
        end else begin
            if (tick) begin
                divider_count <= '0;
            end else if (active) begin
                divider_count <= divider_count + 1'b1;
            end

            if (request.valid && !active) begin
                active        <= 1'b1;
                quarter       <= quarter_setup;
                op            <= request.op;
                divider_count <= '0;
            end else if (tick) begin
                case (quarter)
                    quarter_setup: quarter <= quarter_rise;
                    quarter_rise: begin
                        quarter       <= quarter_high;
                        stretch_count <= '0;
                    end
                    quarter_high: begin
                        // target may still hold SCL low
                        if (high_complete) begin
                            quarter <= quarter_fall;
                        end else if (scl_in) begin
                            // SCL freed by the target gets one more full high quarter
                            stretch_count <= '0;
                        end else if (stretch_expired) begin
                            active  <= 1'b0;
                            op      <= op_stop;
                            quarter <= quarter_fall;
                        end else begin
                            stretch_count <= stretch_next;
                        end
                    end
                    default: active <= 1'b0;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (request.valid && !active) begin
            send_value <= request.sda;
        end
    end

    // SDA moves only under a low SCL except for start, restart and stop edges
    a_sda_stable_high: assert property (
        @(posedge clock) disable iff (!reset_n)
        !$stable(sda_drive_low) |-> $past(scl_drive_low) ||
                                    ((quarter == quarter_fall) && !data_op)
    ) else $error("SDA changed while SCL was high during a data bit");

endmodule

`default_nettype wire

// ==== hdl/i2c_bus_pkg.sv ====
`default_nettype none

package i2c_bus_pkg;

    ////////////////////////////////////////////////////////////
    // bit level operations
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        op_start,
        op_restart,
        op_send_bit,
        op_receive_bit,
        op_stop
    } bit_op_t;

    // one bit is split into four equal quarters
    typedef enum logic [1:0] {
        quarter_setup,
        quarter_rise,
        quarter_high,
        quarter_fall
    } quarter_t;

    ////////////////////////////////////////////////////////////
    // transfer sequencing
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_address_write,
        st_address_ack,
        st_register,
        st_register_ack,
        st_data_write,
        st_data_ack,
        st_restart,
        st_address_read,
        st_address_read_ack,
        st_data_read,
        st_nack,
        st_stop
    } transfer_state_t;

    // sequencer to bit engine
    typedef struct packed {
        logic    valid;
        bit_op_t op;
        logic    sda;
    } bit_request_t;

    // bit engine to sequencer and read capture
    typedef struct packed {
        logic    done;
        logic    aborted;
        logic    sample_strobe;
        // operation the pulses belong to
        bit_op_t op;
    } bit_status_t;

endpackage

`default_nettype wire

// ==== hdl/i2c_master.sv ====
`default_nettype none

module i2c_master (
    input  logic                             clock,
    input  logic                             reset_n,
    input  logic                             enable,
    input  logic                             read_write,
    input  i2c_types_pkg::device_address_t   device_address,
    input  i2c_types_pkg::register_address_t register_address,
    input  i2c_types_pkg::data_byte_t        mosi_data,
    input  i2c_types_pkg::divider_t          divider,
    output i2c_types_pkg::data_byte_t        miso_data,
    output logic                             busy,
    inout  wire                              serial_data,
    inout  wire                              serial_clock
);
    import i2c_bus_pkg::*;

    bit_request_t request;
    bit_status_t  status;
    logic         scl_drive_low;
    logic         sda_drive_low;
    logic         ack_received;
    logic         scl_in;
    logic         sda_in;

    ////////////////////////////////////////////////////////////
    // open-drain pads
    ////////////////////////////////////////////////////////////

    assign serial_clock = scl_drive_low ? 1'b0 : 1'bz;
    assign serial_data  = sda_drive_low ? 1'b0 : 1'bz;

    // resolved bus levels, including what targets drive
    assign scl_in = serial_clock;
    assign sda_in = serial_data;

    i2c_transfer_sequencer i2c_transfer_sequencer_inst (
        .clock            (clock),
        .reset_n          (reset_n),
        .enable           (enable),
        .read_write       (read_write),
        .device_address   (device_address),
        .register_address (register_address),
        .mosi_data        (mosi_data),
        .status           (status),
        .ack_received     (ack_received),
        .request          (request),
        .busy             (busy)
    );

    i2c_bit_engine i2c_bit_engine_inst (
        .clock         (clock),
        .reset_n       (reset_n),
        .divider       (divider),
        .request       (request),
        .scl_in        (scl_in),
        .status        (status),
        .scl_drive_low (scl_drive_low),
        .sda_drive_low (sda_drive_low)
    );

    i2c_read_capture i2c_read_capture_inst (
        .clock        (clock),
        .reset_n      (reset_n),
        .status       (status),
        .sda_in       (sda_in),
        .ack_received (ack_received),
        .miso_data    (miso_data)
    );

endmodule

`default_nettype wire

// ==== hdl/i2c_read_capture.sv ====
`default_nettype none

module i2c_read_capture (
    input  logic                      clock,
    input  logic                      reset_n,
    input  i2c_bus_pkg::bit_status_t  status,
    input  logic                      sda_in,
    output logic                      ack_received,
    output i2c_types_pkg::data_byte_t miso_data
);
    import i2c_bus_pkg::*;

    logic shift_enable;

    // only bits driven by the target go into the read byte
    assign shift_enable = status.sample_strobe && (status.op == op_receive_bit);

    ////////////////////////////////////////////////////////////
    // SDA sampling
    ////////////////////////////////////////////////////////////

    // low SDA in an ack slot means the target answered
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            ack_received <= 1'b0;
        end else if (status.sample_strobe) begin
            ack_received <= !sda_in;
        end
    end

    // MSB first, complete after the eighth receive bit
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            miso_data <= '0;
        end else if (shift_enable) begin
            miso_data <= {miso_data[6:0], sda_in};
        end
    end

    // the engine samples on a high SCL and aborts only on a held low one
    a_sample_not_abort: assert property (
        @(posedge clock) disable iff (!reset_n)
        !(status.sample_strobe && status.aborted)
    ) else $error("sample strobe and abort seen in the same cycle");

endmodule

`default_nettype wire

// ==== hdl/i2c_transfer_sequencer.sv ====
`default_nettype none

module i2c_transfer_sequencer (
    input  logic                             clock,
    input  logic                             reset_n,
    input  logic                             enable,
    input  logic                             read_write,
    input  i2c_types_pkg::device_address_t   device_address,
    input  i2c_types_pkg::register_address_t register_address,
    input  i2c_types_pkg::data_byte_t        mosi_data,
    input  i2c_bus_pkg::bit_status_t         status,
    input  logic                             ack_received,
    output i2c_bus_pkg::bit_request_t        request,
    output logic                             busy
);
    import i2c_types_pkg::*;
    import i2c_bus_pkg::*;

    transfer_state_t   state;
    logic              in_flight;
    logic [2:0]        bit_count;
    logic              byte_state;
    logic              last_bit;

    data_byte_t        shift_byte;
    device_address_t   saved_device;
    register_address_t saved_register;
    data_byte_t        saved_data;
    logic              saved_read;

    assign byte_state = (state == st_address_write) || (state == st_register) ||
                        (state == st_data_write) || (state == st_address_read) ||
                        (state == st_data_read);
    assign last_bit   = (bit_count == 3'd7);

    ////////////////////////////////////////////////////////////
    // next bit operation
    ////////////////////////////////////////////////////////////

    // one request per bit, issued once the engine has finished the last one
    always_comb begin
        request.valid = (state != st_idle) && !in_flight;
        request.op    = op_send_bit;
        // ack slots and the final nack leave SDA released
        request.sda   = 1'b1;
        case (state)
            st_start:       request.op = op_start;
            st_restart:     request.op = op_restart;
            st_stop:        request.op = op_stop;
            st_data_read:   request.op = op_receive_bit;
            st_address_write,
            st_register,
            st_data_write,
            st_address_read: request.sda = shift_byte[7];
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // transfer FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state     <= st_idle;
            in_flight <= 1'b0;
            bit_count <= '0;
            busy      <= 1'b0;
        end else begin
            busy <= (state != st_idle);

            if (request.valid) begin
                in_flight <= 1'b1;
            end
            if (status.done || status.aborted) begin
                in_flight <= 1'b0;
            end

            if (status.aborted) begin
                // timed out on a stretch, no stop condition
                state <= st_idle;
            end else if (state == st_idle) begin
                bit_count <= '0;
                if (enable) begin
                    state <= st_start;
                end
            end else if (status.done) begin
                if (byte_state) begin
                    bit_count <= bit_count + 3'd1;
                end
                case (state)
                    st_start:            state <= st_address_write;
                    st_address_write:    if (last_bit) state <= st_address_ack;
                    st_address_ack:      state <= ack_received ? st_register : st_stop;
                    st_register:         if (last_bit) state <= st_register_ack;
                    st_register_ack: begin
                        if (!ack_received) begin
                            state <= st_stop;
                        end else begin
                            state <= saved_read ? st_restart : st_data_write;
                        end
                    end
                    st_data_write:       if (last_bit) state <= st_data_ack;
                    st_data_ack:         state <= st_stop;
                    st_restart:          state <= st_address_read;
                    st_address_read:     if (last_bit) state <= st_address_read_ack;
                    st_address_read_ack: state <= ack_received ? st_data_read : st_stop;
                    st_data_read:        if (last_bit) state <= st_nack;
                    st_nack:             state <= st_stop;
                    default:             state <= st_idle;
                endcase
            end
        end
    end

    // request fields and the outgoing shift register
    always_ff @(posedge clock) begin
        if (state == st_idle) begin
            saved_device   <= device_address;
            saved_register <= register_address;
            saved_data     <= mosi_data;
            saved_read     <= read_write;
        end
        if (status.done) begin
            case (state)
                st_start:        shift_byte <= {saved_device, write_bit};
                st_restart:      shift_byte <= {saved_device, read_bit};
                st_address_ack:  shift_byte <= saved_register;
                st_register_ack: shift_byte <= saved_data;
                default:         shift_byte <= {shift_byte[6:0], 1'b0};
            endcase
        end
    end

    // one operation at a time, a new one only after the engine reports back
    a_one_op_in_flight: assert property (
        @(posedge clock) disable iff (!reset_n)
        request.valid |=> (!request.valid until (status.done || status.aborted))
    ) else $error("bit request issued while an operation was in progress");

endmodule

`default_nettype wire

// ==== hdl/i2c_types_pkg.sv ====
`default_nettype none

package i2c_types_pkg;

    ////////////////////////////////////////////////////////////
    // transaction fields
    ////////////////////////////////////////////////////////////

    // 7-bit target address, sent ahead of the direction bit
    typedef logic [6:0]  device_address_t;

    // register index inside the target
    typedef logic [7:0]  register_address_t;

    // one byte of write or read data
    typedef logic [7:0]  data_byte_t;

    // clocks per SCL quarter, minus one
    typedef logic [15:0] divider_t;

    // divider ticks spent waiting on a held SCL
    typedef logic [7:0]  stretch_count_t;

    ////////////////////////////////////////////////////////////
    // protocol constants
    ////////////////////////////////////////////////////////////

    // give up on a target that holds SCL low this long
    localparam stretch_count_t stretch_timeout_ticks = 8'd255;

    // direction bit after the address
    localparam logic read_bit  = 1'b1;
    localparam logic write_bit = 1'b0;

endpackage

`default_nettype wire

// ==== verif/i2c_master_cases.txt ====
# op device register write_data stretch_ticks expected_read, all hex
# op 0 is a write, op 1 a read; expected_read is only checked on reads
0 42 03 a5 0 00
1 42 03 00 0 a5
0 42 07 3c 0 00
1 42 07 00 0 3c
0 17 03 ff 0 00
1 42 03 00 0 a5
0 42 05 5a 28 00
1 42 05 00 28 5a
0 42 05 c3 258 00
1 42 05 00 0 5a
1 42 0c 00 0 00
0 42 0a 96 0 00
1 42 0a 00 0 96
0 42 0f 01 0 00
1 42 0f 00 0 01

// ==== verif/i2c_master_tb.sv ====
`default_nettype none

module i2c_master_tb;
    import i2c_types_pkg::*;

    localparam int clock_period = 20;
    localparam int drive_delay  = 2;
    localparam int reset_cycles = 16;
    localparam int wait_limit   = 20000;

    logic              clock;
    logic              reset_n;
    logic              enable;
    logic              read_write;
    device_address_t   device_address;
    register_address_t register_address;
    data_byte_t        mosi_data;
    divider_t          divider;
    data_byte_t        miso_data;
    logic              busy;
    logic [31:0]       stretch_clocks;
    logic [31:0]       lfsr_state;
    int                pass_count;
    int                fail_count;
    wire               serial_data;
    wire               serial_clock;

    pullup (serial_data);
    pullup (serial_clock);

    i2c_master i2c_master_inst (
        .clock            (clock),
        .reset_n          (reset_n),
        .enable           (enable),
        .read_write       (read_write),
        .device_address   (device_address),
        .register_address (register_address),
        .mosi_data        (mosi_data),
        .divider          (divider),
        .miso_data        (miso_data),
        .busy             (busy),
        .serial_data      (serial_data),
        .serial_clock     (serial_clock)
    );

    i2c_slave_model i2c_slave_model_inst (
        .clock          (clock),
        .reset_n        (reset_n),
        .stretch_clocks (stretch_clocks),
        .serial_data    (serial_data),
        .serial_clock   (serial_clock)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // random dividers
    ////////////////////////////////////////////////////////////

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] value);
        return {value[30:0], value[31] ^ value[21] ^ value[1] ^ value[0]};
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    ////////////////////////////////////////////////////////////
    // waits
    ////////////////////////////////////////////////////////////

    task automatic wait_for_busy(input logic level, output logic timed_out);
        int cycles;
        cycles    = 0;
        timed_out = 1'b0;
        while (busy !== level && !timed_out) begin
            @(posedge clock);
            #drive_delay;
            cycles++;
            timed_out = (cycles >= wait_limit);
        end
    endtask

    // a stretching slave may still hold SCL after an abort
    task automatic wait_for_bus_idle(output logic timed_out);
        int cycles;
        cycles    = 0;
        timed_out = 1'b0;
        while ((serial_clock !== 1'b1 || serial_data !== 1'b1) && !timed_out) begin
            @(posedge clock);
            #drive_delay;
            cycles++;
            timed_out = (cycles >= wait_limit);
        end
    endtask

    task automatic run_transfer(output logic failed);
        logic timed_out;
        failed = 1'b0;
        enable = 1'b1;
        wait_for_busy(1'b1, timed_out);
        enable = 1'b0;
        if (timed_out) begin
            $display("timeout at %0t: busy never rose after enable", $time);
            failed = 1'b1;
        end else begin
            wait_for_busy(1'b0, timed_out);
            if (timed_out) begin
                $display("timeout at %0t: busy stayed high, transfer never ended", $time);
                failed = 1'b1;
            end else begin
                wait_for_bus_idle(timed_out);
                if (timed_out) begin
                    $display("timeout at %0t: bus lines not released after transfer", $time);
                    failed = 1'b1;
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // cases
    ////////////////////////////////////////////////////////////

    initial begin
        int          file;
        int          code;
        int          fields;
        int          case_count;
        string       line;
        logic        stopped;
        logic        case_ok;
        logic [31:0] random_value;
        logic [31:0] op_field;
        logic [31:0] address_field;
        logic [31:0] register_field;
        logic [31:0] data_field;
        logic [31:0] stretch_field;
        logic [31:0] expected_field;
        data_byte_t  expected_miso;
        logic        miso_known;

        reset_n          = 1'b0;
        enable           = 1'b0;
        read_write       = 1'b0;
        device_address   = '0;
        register_address = '0;
        mosi_data        = '0;
        divider          = 16'd4;
        stretch_clocks   = '0;
        lfsr_state       = 32'h5d8d28ce;
        pass_count       = 0;
        fail_count       = 0;
        case_count       = 0;
        stopped          = 1'b0;
        expected_miso    = '0;
        miso_known       = 1'b0;

        repeat (reset_cycles) @(posedge clock);
        #drive_delay;
        reset_n = 1'b1;
        @(posedge clock);
        #drive_delay;

        if (busy !== 1'b0 || serial_clock !== 1'b1 || serial_data !== 1'b1) begin
            $display("error at %0t: after reset busy=%b scl=%b sda=%b", $time, busy,
                     serial_clock, serial_data);
            fail_count++;
            $display("reset state: FAIL");
        end else begin
            pass_count++;
            $display("reset state: ok");
        end

        file = $fopen("verif/i2c_master_cases.txt", "r");
        if (file == 0) begin
            $display("could not open the case file verif/i2c_master_cases.txt");
            fail_count++;
            stopped = 1'b1;
        end

        while (!stopped && !$feof(file)) begin
            code = $fgets(line, file);
            if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h %h", op_field, address_field,
                                 register_field, data_field, stretch_field, expected_field);
                if (fields != 6) begin
                    $display("malformed line in the case file: %s", line);
                    fail_count++;
                end else begin
                    case_count++;
                    random_bits(3, random_value);
                    @(posedge clock);
                    #drive_delay;
                    divider          = divider_t'(random_value) + 16'd2;
                    stretch_clocks   = stretch_field * (divider + 32'd1);
                    read_write       = op_field[0];
                    device_address   = address_field[6:0];
                    register_address = register_field[7:0];
                    mosi_data        = data_field[7:0];
                    run_transfer(stopped);
                    case_ok = !stopped;
                    if (!stopped && op_field[0] && miso_data !== expected_field[7:0]) begin
                        $display("error at %0t: read 0x%02h from 0x%02h reg 0x%02h, expected 0x%02h",
                                 $time, miso_data, device_address, register_address,
                                 expected_field[7:0]);
                        case_ok = 1'b0;
                    end
                    if (!stopped && !op_field[0] && miso_known &&
                        miso_data !== expected_miso) begin
                        $display("error at %0t: write changed miso_data from 0x%02h to 0x%02h",
                                 $time, expected_miso, miso_data);
                        case_ok = 1'b0;
                    end
                    // last byte read stays on miso_data until the next read
                    if (op_field[0]) begin
                        expected_miso = expected_field[7:0];
                        miso_known    = 1'b1;
                    end
                    if (case_ok) begin
                        pass_count++;
                    end else begin
                        fail_count++;
                    end
                    $display("case %0d: %s dev 0x%02h reg 0x%02h divider %0d stretch %0d: %s",
                             case_count, op_field[0] ? "read " : "write", device_address,
                             register_address, divider, stretch_field, case_ok ? "ok" : "FAIL");
                end
            end
        end
        if (file != 0) begin
            $fclose(file);
        end

        if (case_count == 0) begin
            $display("no cases were run");
        end
        $display("%0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && case_count > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/i2c_slave_model.sv ====
`default_nettype none

module i2c_slave_model (
    input  logic        clock,
    input  logic        reset_n,
    input  logic [31:0] stretch_clocks,
    inout  wire         serial_data,
    inout  wire         serial_clock
);
    import i2c_types_pkg::*;

    localparam device_address_t own_address = 7'h42;

    typedef enum {
        slave_idle,
        slave_address,
        slave_address_ack,
        slave_register,
        slave_register_ack,
        slave_data,
        slave_data_ack,
        slave_send,
        slave_send_ack
    } slave_state_t;

    slave_state_t state;
    data_byte_t   registers [16];
    data_byte_t   shift;
    data_byte_t   send_byte;
    logic [3:0]   pointer;
    logic [3:0]   bit_count;
    logic         reading;
    logic         scl_low;
    logic         sda_low;
    logic         scl_prev;
    logic         sda_prev;
    logic         scl_now;
    logic         sda_now;
    logic [31:0]  stretch_left;

    assign serial_clock = scl_low ? 1'b0 : 1'bz;
    assign serial_data  = sda_low ? 1'b0 : 1'bz;

    ////////////////////////////////////////////////////////////
    // bus oversampling, away from the master's clock edge
    ////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!reset_n) begin
            for (int i = 0; i < 16; i++) begin
                registers[i] = '0;
            end
            state        = slave_idle;
            shift        = '0;
            send_byte    = '0;
            pointer      = '0;
            bit_count    = '0;
            reading      = 1'b0;
            scl_low      = 1'b0;
            sda_low      = 1'b0;
            scl_prev     = 1'b1;
            sda_prev     = 1'b1;
            stretch_left = '0;
        end else begin
            scl_now = (serial_clock !== 1'b0);
            sda_now = (serial_data !== 1'b0);
            if (stretch_left != 0) begin
                stretch_left = stretch_left - 1;
                if (stretch_left == 0) begin
                    scl_low = 1'b0;
                end
            end
            if (scl_prev && scl_now && sda_prev && !sda_now) begin
                // start or repeated start
                state     = slave_address;
                bit_count = '0;
                sda_low   = 1'b0;
            end else if (scl_prev && scl_now && !sda_prev && sda_now) begin
                state   = slave_idle;
                sda_low = 1'b0;
            end else if (!scl_prev && scl_now) begin
                case (state)
                    slave_address, slave_register, slave_data: begin
                        shift     = {shift[6:0], sda_now};
                        bit_count = bit_count + 1;
                    end
                    slave_send: bit_count = bit_count + 1;
                    default: ;
                endcase
            end else if (scl_prev && !scl_now) begin
                case (state)
                    slave_address: begin
                        if (bit_count == 8 && shift[7:1] == own_address) begin
                            reading = shift[0];
                            sda_low = 1'b1;
                            state   = slave_address_ack;
                        end else if (bit_count == 8) begin
                            state = slave_idle;
                        end
                    end
                    slave_register: begin
                        if (bit_count == 8) begin
                            pointer = shift[3:0];
                            sda_low = 1'b1;
                            state   = slave_register_ack;
                        end
                    end
                    slave_data: begin
                        if (bit_count == 8) begin
                            registers[pointer] = shift;
                            sda_low            = 1'b1;
                            state              = slave_data_ack;
                        end
                    end
                    slave_address_ack: begin
                        bit_count = '0;
                        if (reading) begin
                            send_byte = registers[pointer];
                            sda_low   = !send_byte[7];
                            state     = slave_send;
                        end else begin
                            sda_low = 1'b0;
                            state   = slave_register;
                            // hold SCL low before the register byte
                            if (stretch_clocks != 0) begin
                                scl_low      = 1'b1;
                                stretch_left = stretch_clocks;
                            end
                        end
                    end
                    slave_register_ack: begin
                        sda_low   = 1'b0;
                        bit_count = '0;
                        state     = slave_data;
                    end
                    slave_send: begin
                        if (bit_count == 8) begin
                            sda_low = 1'b0;
                            state   = slave_send_ack;
                        end else begin
                            sda_low = !send_byte[7 - bit_count];
                        end
                    end
                    slave_data_ack, slave_send_ack: begin
                        sda_low = 1'b0;
                        state   = slave_idle;
                    end
                    default: ;
                endcase
            end
            scl_prev = scl_now;
            sda_prev = sda_now;
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/i2c_types_pkg.sv
hdl/i2c_bus_pkg.sv
hdl/i2c_transfer_sequencer.sv
hdl/i2c_bit_engine.sv
hdl/i2c_read_capture.sv
hdl/i2c_master.sv
verif/i2c_slave_model.sv
verif/i2c_master_tb.sv
